// File: include/exUnit_defines.svh
`ifndef EXUNIT_DEFINES_SVH
`define EXUNIT_DEFINES_SVH

// datapath widths
`define EX_XLEN   64
`define EX_IMMW   32
`define EX_REGIDW 7

// multiplier operand and partial-product slice widths
`define EX_HALFW  32
`define EX_PPW    16

// shift amount field taken from the immediate
`define EX_SHW    6

// mulOp encodings carried from stage 2 into stage 3
`define EX_MUL_NONE 2'd0
`define EX_MUL_U    2'd1
`define EX_MUL_S    2'd2

`endif

// File: hw/exPkg.sv
`default_nettype none

`include "exUnit_defines.svh"

package exPkg;

	typedef enum logic [4:0] {
		OP_NOP,
		OP_MOVRR,
		OP_MOVIR,
		OP_ADD,
		OP_SUB,
		OP_ADC,
		OP_SBB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_TST,
		OP_CMPEQ,
		OP_CMPHI,
		OP_CMPGT,
		OP_EXTUB,
		OP_EXTSB,
		OP_SHLL,
		OP_SHLR,
		OP_SHAR,
		OP_LEA,
		OP_BRA,
		OP_BSR,
		OP_BT,
		OP_BF,
		OP_JMP,
		OP_MULU,
		OP_MULS,
		OP_CLRT,
		OP_SETT
	} exOpE;

	// source of the address index
	typedef enum logic [1:0] {
		IDX_NONE,
		IDX_IMM,
		IDX_REG
	} exIdxE;

	typedef struct packed {
		exOpE                    op;
		logic [`EX_REGIDW-1:0]   regIdRn;
		logic [`EX_XLEN-1:0]     valRn;
		logic [`EX_XLEN-1:0]     valRm;
		logic [`EX_IMMW-1:0]     imm32;
		exIdxE                   idxSel;
		logic [1:0]              idxScale;	// index << 0..3
		logic [`EX_XLEN-1:0]     nextPc;
	} exInOpT;

	typedef struct packed {
		exOpE                    op;
		logic [`EX_REGIDW-1:0]   regIdRn;
		logic [`EX_XLEN-1:0]     valRn;
		logic [`EX_XLEN-1:0]     valRm;
		logic [`EX_XLEN-1:0]     immSx;
		logic [`EX_XLEN-1:0]     addr;
		logic [`EX_XLEN-1:0]     nextPc;
	} exOpndT;

	typedef struct packed {
		logic [`EX_REGIDW-1:0]   regId;
		logic [`EX_XLEN-1:0]     regVal;
		logic                    regWe;
		logic [1:0]              mulOp;
		logic [`EX_HALFW-1:0]    mulA;
		logic [`EX_HALFW-1:0]    mulB;
		logic                    tBit;
		logic                    brTaken;
		logic [`EX_XLEN-1:0]     brTarget;
	} exAluT;

	typedef struct packed {
		logic [`EX_REGIDW-1:0]   regId;
		logic [`EX_XLEN-1:0]     regVal;
		logic                    regWe;
		logic                    tBit;
		logic                    brTaken;
		logic [`EX_XLEN-1:0]     brTarget;
	} exResT;

endpackage

`default_nettype wire

// File: hw/exOperandStage.sv
`timescale 1ns/100ps
`default_nettype none

`include "exUnit_defines.svh"

module exOperandStage (
	input  wire logic          clock,
	input  wire logic          rst,
	input  wire logic          inValid,
	output logic               inReady,
	input  exPkg::exInOpT      inOp,
	output logic               outValid,
	input  wire logic          outReady,
	output exPkg::exOpndT      outOpnd
);
	import exPkg::*;

	logic                  take;
	logic [`EX_XLEN-1:0]   immSx;
	logic [`EX_XLEN-1:0]   idxVal;
	logic [`EX_XLEN-1:0]   idxScaled;
	logic [`EX_XLEN-1:0]   base;
	exOpndT                nextOpnd;

	// stage is free when empty or the next stage takes our entry
	assign inReady = !outValid || outReady;
	assign take = inValid && inReady;

	assign immSx = {{(`EX_XLEN-`EX_IMMW){inOp.imm32[`EX_IMMW-1]}}, inOp.imm32};

	always_comb begin
		case (inOp.idxSel)
			IDX_IMM: idxVal = immSx;
			IDX_REG: idxVal = inOp.valRm;
			default: idxVal = '0;	// IDX_NONE and the spare code
		endcase
	end

	assign idxScaled = idxVal << inOp.idxScale;

	// pc relative for branches, register base for LEA and the rest
	always_comb begin
		if (inOp.op inside {OP_BRA, OP_BSR, OP_BT, OP_BF})
			base = inOp.nextPc;
		else
			base = inOp.valRn;
	end

	always_comb begin
		nextOpnd.op      = inOp.op;
		nextOpnd.regIdRn = inOp.regIdRn;
		nextOpnd.valRn   = inOp.valRn;
		nextOpnd.valRm   = inOp.valRm;
		nextOpnd.immSx   = immSx;
		nextOpnd.addr    = base + idxScaled;
		nextOpnd.nextPc  = inOp.nextPc;
	end

	always_ff @(posedge clock) begin
		if (rst)
			outValid <= 1'b0;
		else if (inReady)
			outValid <= inValid;
	end

	always_ff @(posedge clock) begin
		if (take)
			outOpnd <= nextOpnd;
	end

endmodule

`default_nettype wire

// File: hw/exAluStage.sv
`timescale 1ns/100ps
`default_nettype none

`include "exUnit_defines.svh"

module exAluStage (
	input  wire logic          clock,
	input  wire logic          rst,
	input  wire logic          inValid,
	output logic               inReady,
	input  exPkg::exOpndT      inOpnd,
	output logic               outValid,
	input  wire logic          outReady,
	output exPkg::exAluT       outAlu
);
	import exPkg::*;

	logic                  tReg;		// architectural T bit
	logic                  take;
	logic [`EX_XLEN:0]     wideSum;		// carry in the top bit
	logic [`EX_SHW-1:0]    shAmt;
	exAluT                 nextAlu;

	assign inReady = !outValid || outReady;
	assign take = inValid && inReady;
	assign shAmt = inOpnd.immSx[`EX_SHW-1:0];

	always_comb begin
		nextAlu = '0;
		nextAlu.regId = inOpnd.regIdRn;
		nextAlu.tBit = tReg;
		nextAlu.mulOp = `EX_MUL_NONE;
		wideSum = '0;

		case (inOpnd.op)
			OP_MOVRR: begin
				nextAlu.regVal = inOpnd.valRm;
				nextAlu.regWe = 1'b1;
			end
			OP_MOVIR: begin
				nextAlu.regVal = inOpnd.immSx;
				nextAlu.regWe = 1'b1;
			end
			OP_ADD: begin
				nextAlu.regVal = inOpnd.valRn + inOpnd.valRm;
				nextAlu.regWe = 1'b1;
			end
			OP_SUB: begin
				nextAlu.regVal = inOpnd.valRn - inOpnd.valRm;
				nextAlu.regWe = 1'b1;
			end
			OP_ADC: begin
				wideSum = {1'b0, inOpnd.valRn} + {1'b0, inOpnd.valRm}
					+ {{`EX_XLEN{1'b0}}, tReg};
				nextAlu.regVal = wideSum[`EX_XLEN-1:0];
				nextAlu.regWe = 1'b1;
				nextAlu.tBit = wideSum[`EX_XLEN];
			end
			OP_SBB: begin
				// carry in is ~T so a set T takes one more off
				wideSum = {1'b0, inOpnd.valRn} + {1'b0, ~inOpnd.valRm}
					+ {{`EX_XLEN{1'b0}}, ~tReg};
				nextAlu.regVal = wideSum[`EX_XLEN-1:0];
				nextAlu.regWe = 1'b1;
				nextAlu.tBit = wideSum[`EX_XLEN];
			end
			OP_AND: begin
				nextAlu.regVal = inOpnd.valRn & inOpnd.valRm;
				nextAlu.regWe = 1'b1;
			end
			OP_OR: begin
				nextAlu.regVal = inOpnd.valRn | inOpnd.valRm;
				nextAlu.regWe = 1'b1;
			end
			OP_XOR: begin
				nextAlu.regVal = inOpnd.valRn ^ inOpnd.valRm;
				nextAlu.regWe = 1'b1;
			end
			OP_TST: nextAlu.tBit = ((inOpnd.valRn[31:0] & inOpnd.valRm[31:0]) == '0);
			OP_CMPEQ: nextAlu.tBit = (inOpnd.valRn == inOpnd.valRm);
			OP_CMPHI: nextAlu.tBit = (inOpnd.valRn > inOpnd.valRm);
			OP_CMPGT: nextAlu.tBit = ($signed(inOpnd.valRn) > $signed(inOpnd.valRm));
			OP_EXTUB: begin
				nextAlu.regVal = {{(`EX_XLEN-8){1'b0}}, inOpnd.valRn[7:0]};
				nextAlu.regWe = 1'b1;
			end
			OP_EXTSB: begin
				nextAlu.regVal = {{(`EX_XLEN-8){inOpnd.valRn[7]}}, inOpnd.valRn[7:0]};
				nextAlu.regWe = 1'b1;
			end
			OP_SHLL: begin
				nextAlu.regVal = inOpnd.valRn << shAmt;
				nextAlu.regWe = 1'b1;
			end
			OP_SHLR: begin
				nextAlu.regVal = inOpnd.valRn >> shAmt;
				nextAlu.regWe = 1'b1;
			end
			OP_SHAR: begin
				nextAlu.regVal = $signed(inOpnd.valRn) >>> shAmt;
				nextAlu.regWe = 1'b1;
			end
			OP_LEA: begin
				nextAlu.regVal = inOpnd.addr;
				nextAlu.regWe = 1'b1;
			end
			OP_BRA: begin
				nextAlu.brTaken = 1'b1;
				nextAlu.brTarget = inOpnd.addr;
			end
			OP_BSR: begin
				nextAlu.brTaken = 1'b1;
				nextAlu.brTarget = inOpnd.addr;
				nextAlu.regVal = inOpnd.nextPc;	// link
				nextAlu.regWe = 1'b1;
			end
			OP_BT: begin
				nextAlu.brTaken = tReg;
				nextAlu.brTarget = inOpnd.addr;
			end
			OP_BF: begin
				nextAlu.brTaken = !tReg;
				nextAlu.brTarget = inOpnd.addr;
			end
			OP_JMP: begin
				nextAlu.brTaken = 1'b1;
				nextAlu.brTarget = inOpnd.valRn;
			end
			OP_MULU, OP_MULS: begin
				// product filled in by stage 3
				nextAlu.mulOp = (inOpnd.op == OP_MULS) ? `EX_MUL_S : `EX_MUL_U;
				nextAlu.mulA = inOpnd.valRn[`EX_HALFW-1:0];
				nextAlu.mulB = inOpnd.valRm[`EX_HALFW-1:0];
				nextAlu.regWe = 1'b1;
			end
			OP_CLRT: nextAlu.tBit = 1'b0;
			OP_SETT: nextAlu.tBit = 1'b1;
			default: begin
			end
		endcase
	end

	// T only moves when a micro-op actually leaves for stage 3
	always_ff @(posedge clock) begin
		if (rst) begin
			outValid <= 1'b0;
			tReg <= 1'b0;
		end else begin
			if (inReady)
				outValid <= inValid;
			if (take)
				tReg <= nextAlu.tBit;
		end
	end

	always_ff @(posedge clock) begin
		if (take)
			outAlu <= nextAlu;
	end

endmodule

`default_nettype wire

// File: hw/exMulStage.sv
`timescale 1ns/100ps
`default_nettype none

`include "exUnit_defines.svh"

module exMulStage (
	input  wire logic          clock,
	input  wire logic          rst,
	input  wire logic          inValid,
	output logic               inReady,
	input  exPkg::exAluT       inAlu,
	output logic               outValid,
	input  wire logic          outReady,
	output exPkg::exResT       res
);
	import exPkg::*;

	typedef struct packed {
		exResT                   pass;
		logic                    isMul;
		logic [2*`EX_PPW-1:0]    ppLL;
		logic [2*`EX_PPW-1:0]    ppLH;
		logic [2*`EX_PPW-1:0]    ppHL;
		logic [2*`EX_PPW-1:0]    ppHH;
		logic [`EX_HALFW-1:0]    corr;	// signed fixup for the upper half
	} mulStgT;

	logic                  take;
	logic [`EX_PPW-1:0]    aLo;
	logic [`EX_PPW-1:0]    aHi;
	logic [`EX_PPW-1:0]    bLo;
	logic [`EX_PPW-1:0]    bHi;
	logic [`EX_HALFW-1:0]  corrA;
	logic [`EX_HALFW-1:0]  corrB;
	logic [`EX_XLEN-1:0]   prod;
	mulStgT                nextStg;
	mulStgT                stg;

	assign inReady = !outValid || outReady;
	assign take = inValid && inReady;

	assign aLo = inAlu.mulA[`EX_PPW-1:0];
	assign aHi = inAlu.mulA[`EX_HALFW-1:`EX_PPW];
	assign bLo = inAlu.mulB[`EX_PPW-1:0];
	assign bHi = inAlu.mulB[`EX_HALFW-1:`EX_PPW];

	// a negative operand weighs -2^32, so take the other operand off the top
	assign corrA = inAlu.mulA[`EX_HALFW-1] ? -inAlu.mulB : '0;
	assign corrB = inAlu.mulB[`EX_HALFW-1] ? -inAlu.mulA : '0;

	always_comb begin
		nextStg.pass.regId    = inAlu.regId;
		nextStg.pass.regVal   = inAlu.regVal;
		nextStg.pass.regWe    = inAlu.regWe;
		nextStg.pass.tBit     = inAlu.tBit;
		nextStg.pass.brTaken  = inAlu.brTaken;
		nextStg.pass.brTarget = inAlu.brTarget;
		nextStg.isMul = (inAlu.mulOp != `EX_MUL_NONE);
		nextStg.ppLL = aLo * bLo;
		nextStg.ppLH = aLo * bHi;
		nextStg.ppHL = aHi * bLo;
		nextStg.ppHH = aHi * bHi;
		nextStg.corr = (inAlu.mulOp == `EX_MUL_S) ? (corrA + corrB) : '0;
	end

	always_ff @(posedge clock) begin
		if (rst)
			outValid <= 1'b0;
		else if (inReady)
			outValid <= inValid;
	end

	always_ff @(posedge clock) begin
		if (take)
			stg <= nextStg;
	end

	assign prod = {{`EX_HALFW{1'b0}}, stg.ppLL}
		+ {{`EX_PPW{1'b0}}, stg.ppLH, {`EX_PPW{1'b0}}}
		+ {{`EX_PPW{1'b0}}, stg.ppHL, {`EX_PPW{1'b0}}}
		+ {stg.ppHH, {`EX_HALFW{1'b0}}}
		+ {stg.corr, {`EX_HALFW{1'b0}}};

	always_comb begin
		res = stg.pass;
		if (stg.isMul)
			res.regVal = prod;
	end

endmodule

`default_nettype wire

// File: hw/exUnit.sv
`timescale 1ns/100ps
`default_nettype none

module exUnit (
	input  wire logic          clock,
	input  wire logic          rst,
	input  wire logic          inValid,
	output logic               inReady,
	input  exPkg::exInOpT      inOp,
	output logic               resValid,
	input  wire logic          resReady,
	output exPkg::exResT       res
);
	import exPkg::*;

	// stage 1 to 2
	logic      opndValid;
	logic      opndReady;
	exOpndT    opnd;

	// stage 2 to 3
	logic      aluValid;
	logic      aluReady;
	exAluT     alu;

	exOperandStage operandStage_i (
		.clock    (clock),
		.rst      (rst),
		.inValid  (inValid),
		.inReady  (inReady),
		.inOp     (inOp),
		.outValid (opndValid),
		.outReady (opndReady),
		.outOpnd  (opnd)
	);

	exAluStage aluStage_i (
		.clock    (clock),
		.rst      (rst),
		.inValid  (opndValid),
		.inReady  (opndReady),
		.inOpnd   (opnd),
		.outValid (aluValid),
		.outReady (aluReady),
		.outAlu   (alu)
	);

	exMulStage mulStage_i (
		.clock    (clock),
		.rst      (rst),
		.inValid  (aluValid),
		.inReady  (aluReady),
		.inAlu    (alu),
		.outValid (resValid),
		.outReady (resReady),
		.res      (res)
	);

endmodule

`default_nettype wire

// File: dv/exUnitTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "exUnit_defines.svh"

module exUnitTb;
	import exPkg::*;

	// what one trace line expects back
	typedef struct packed {
		int                      lineNo;
		logic [`EX_REGIDW-1:0]   regId;
		logic                    regWe;
		logic [`EX_XLEN-1:0]     regVal;
		logic                    tBit;
		logic                    brTaken;
		logic [`EX_XLEN-1:0]     brTarget;
	} expT;

	logic          clock;
	logic          rst;
	logic          inValid;
	logic          inReady;
	exInOpT        inOp;
	logic          resValid;
	logic          resReady;
	exResT         res;

	exInOpT        stimQ[$];
	expT           expQ[$];
	int            nOps;
	int            cycles;
	logic [31:0]   stimLfsr;	// input gaps
	logic [31:0]   readyLfsr;	// output back-pressure

	exUnit exUnit_i (
		.clock    (clock),
		.rst      (rst),
		.inValid  (inValid),
		.inReady  (inReady),
		.inOp     (inOp),
		.resValid (resValid),
		.resReady (resReady),
		.res      (res)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic checkVal(input string what, input logic [63:0] got, input logic [63:0] want);
		if (got !== want) begin
			$display("ERR %0d ns: %s is %h, expected %h", $time, what, got, want);
			abortRun("stopping at the first mismatch");
		end
	endtask

	// limit of 40 cycles per micro-op plus slack
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (nOps > 0 && cycles > 40 * nOps + 100)
			abortRun($sformatf("timeout after %0d cycles with results still missing", cycles));
	end

	// galois form with taps 32 22 2 1
	function automatic logic lfsrBit(inout logic [31:0] state);
		logic b;
		b = state[0];
		state = state >> 1;
		if (b)
			state = state ^ 32'h80200003;
		return b;
	endfunction

	function automatic logic lookupOp(input string name, output exOpE op);
		exOpE e;
		e = e.first();
		op = OP_NOP;
		for (int i = 0; i < e.num(); i++) begin
			if (e.name() == {"OP_", name}) begin
				op = e;
				return 1'b1;
			end
			e = e.next();
		end
		return 1'b0;
	endfunction

	task automatic readTrace();
		int fd;
		int n;
		int lineNo;
		string line;
		string name;
		exOpE opc;
		exInOpT op;
		expT e;
		logic [63:0] f [12];
		fd = $fopen("dv/exUnit_trace.txt", "r");
		if (fd == 0)
			abortRun("cannot open the trace file dv/exUnit_trace.txt");
		lineNo = 0;
		while ($fgets(line, fd) != 0) begin
			lineNo++;
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h", name,
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
			if (n != 13 || !lookupOp(name, opc))
				abortRun($sformatf("trace line %0d cannot be parsed: %s", lineNo, line));
			op.op = opc;
			op.regIdRn = f[0][`EX_REGIDW-1:0];
			op.valRn = f[1];
			op.valRm = f[2];
			op.imm32 = f[3][`EX_IMMW-1:0];
			op.idxSel = exIdxE'(f[4][1:0]);
			op.idxScale = f[5][1:0];
			op.nextPc = f[6];
			e.lineNo = lineNo;
			e.regId = f[0][`EX_REGIDW-1:0];	// writes always go to Rn
			e.regWe = f[7][0];
			e.regVal = f[8];
			e.tBit = f[9][0];
			e.brTaken = f[10][0];
			e.brTarget = f[11];
			stimQ.push_back(op);
			expQ.push_back(e);
		end
		$fclose(fd);
		nOps = stimQ.size();
		if (nOps == 0)
			abortRun("the trace file holds no micro-ops");
	endtask

	// handshakes sampled at the falling edge and inputs driven 2 ns after the rising one
	task automatic sendOps();
		int idx;
		logic fire;
		idx = 0;
		while (idx < nOps) begin
			@(negedge clock);
			fire = inValid && inReady;
			@(posedge clock);
			#2;
			if (fire)
				idx++;
			if (fire || !inValid) begin
				// valid three times in four so the pipeline fills up
				if (idx < nOps && (lfsrBit(stimLfsr) || lfsrBit(stimLfsr))) begin
					inValid = 1'b1;
					inOp = stimQ[idx];
				end else begin
					inValid = 1'b0;
				end
			end
		end
	endtask

	task automatic checkResults();
		expT e;
		while (expQ.size() > 0) begin
			@(negedge clock);
			if (resValid && resReady) begin
				e = expQ.pop_front();
				checkVal($sformatf("line %0d regWe", e.lineNo), res.regWe, e.regWe);
				if (e.regWe) begin
					checkVal($sformatf("line %0d regId", e.lineNo), res.regId, e.regId);
					checkVal($sformatf("line %0d regVal", e.lineNo), res.regVal, e.regVal);
				end
				checkVal($sformatf("line %0d tBit", e.lineNo), res.tBit, e.tBit);
				checkVal($sformatf("line %0d brTaken", e.lineNo), res.brTaken, e.brTaken);
				if (e.brTaken)
					checkVal($sformatf("line %0d brTarget", e.lineNo), res.brTarget, e.brTarget);
			end
			@(posedge clock);
			#2;
			resReady = lfsrBit(readyLfsr);
		end
	endtask

	initial begin
		rst = 1'b1;
		inValid = 1'b0;
		inOp = '0;
		resReady = 1'b0;
		cycles = 0;
		nOps = 0;
		stimLfsr = 32'h0b25a249;
		readyLfsr = 32'h0b25a249;
		readTrace();
		for (int c = 0; c < 16; c++) begin
			@(posedge clock);
			#2;
			checkVal("resValid during reset", resValid, 1'b0);
		end
		rst = 1'b0;
		checkVal("inReady after reset", inReady, 1'b1);
		fork
			sendOps();
			checkResults();
		join
		// a duplicate would still be waiting in the pipeline
		resReady = 1'b1;
		repeat (4) begin
			@(negedge clock);
			checkVal("resValid after the last result", resValid, 1'b0);
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
hw/exPkg.sv
hw/exOperandStage.sv
hw/exAluStage.sv
hw/exMulStage.sv
hw/exUnit.sv
dv/exUnitTb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the run from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal --top-module exUnitTb -f list.f > build.log 2>&1 ||
	{ echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/VexUnitTb > sim.log 2>&1
grep -q "TB FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "simulation ended without a verdict, see sim.log"; exit 1; }
echo "simulation passed"

// File: dv/exUnit_trace.txt
# op rn valRn valRm imm32 idxSel(0 none, 1 imm, 2 reg) idxScale nextPc, then the expected
# regWe regVal tBit brTaken brTarget; all numbers hex, T is zero after reset
ADD 01 5 7 0 0 0 100 1 c 0 0 0
ADD 02 ffffffffffffffff 1 0 0 0 104 1 0 0 0 0
SUB 03 3 5 0 0 0 108 1 fffffffffffffffe 0 0 0
SUB 04 8000000000000000 1 0 0 0 10c 1 7fffffffffffffff 0 0 0
AND 05 f0f0 ff00 0 0 0 110 1 f000 0 0 0
OR 06 f0f0 0f0f 0 0 0 114 1 ffff 0 0 0
XOR 07 ffffffffffffffff 5555555555555555 0 0 0 118 1 aaaaaaaaaaaaaaaa 0 0 0
MOVRR 08 0 123456789abcdef0 0 0 0 11c 1 123456789abcdef0 0 0 0
MOVIR 09 0 0 80000000 0 0 120 1 ffffffff80000000 0 0 0
MOVIR 0a 0 0 7fffffff 0 0 124 1 7fffffff 0 0 0
EXTUB 0b 12345680 0 0 0 0 128 1 80 0 0 0
EXTSB 0c 1234568f 0 0 0 0 12c 1 ffffffffffffff8f 0 0 0
EXTSB 0d 7f 0 0 0 0 130 1 7f 0 0 0
SHLL 0e 1 0 3f 0 0 134 1 8000000000000000 0 0 0
SHLR 0f 8000000000000000 0 4 0 0 138 1 800000000000000 0 0 0
SHAR 10 8000000000000000 0 3f 0 0 13c 1 ffffffffffffffff 0 0 0
SHAR 11 f0 0 44 0 0 140 1 f 0 0 0
SETT 00 0 0 0 0 0 144 0 0 1 0 0
ADC 12 ffffffffffffffff 0 0 0 0 148 1 0 1 0 0
ADC 13 1 2 0 0 0 14c 1 4 0 0 0
CLRT 00 0 0 0 0 0 150 0 0 0 0 0
SBB 14 5 3 0 0 0 154 1 2 1 0 0
SBB 15 0 0 0 0 0 158 1 ffffffffffffffff 0 0 0
SBB 16 0 0 0 0 0 15c 1 0 1 0 0
TST 00 ff00000000 ff00000000 0 0 0 160 0 0 1 0 0
TST 00 3 2 0 0 0 164 0 0 0 0 0
CMPEQ 00 5 5 0 0 0 168 0 0 1 0 0
BT 00 0 0 fffffff0 1 1 1000 0 0 1 1 fe0
BF 00 0 0 10 1 0 2000 0 0 1 0 0
CMPHI 00 ffffffffffffffff 1 0 0 0 16c 0 0 1 0 0
CMPGT 00 ffffffffffffffff 1 0 0 0 170 0 0 0 0 0
BF 00 0 8 0 2 2 3000 0 0 0 1 3020
BT 00 0 0 0 0 0 4000 0 0 0 0 0
CMPGT 00 1 8000000000000000 0 0 0 174 0 0 1 0 0
LEA 17 1000 0 0 0 3 178 1 1000 1 0 0
LEA 18 1000 0 ffffffff 1 3 17c 1 ff8 1 0 0
LEA 19 1000 10 0 2 2 180 1 1040 1 0 0
LEA 1a 1000 3 0 2 1 184 1 1006 1 0 0
LEA 1b 1000 0 4 1 0 188 1 1004 1 0 0
BRA 00 0 0 100 1 0 5000 0 0 1 1 5100
BSR 0f 0 0 fffff000 1 2 6000 1 6000 1 1 2000
JMP 00 deadbeef0 0 0 0 0 18c 0 0 1 1 deadbeef0
MULU 1c ffffffff ffffffff 0 0 0 190 1 fffffffe00000001 1 0 0
MULS 1d ffffffff ffffffff 0 0 0 194 1 1 1 0 0
MULS 1e ffffffff 2 0 0 0 198 1 fffffffffffffffe 1 0 0
MULU 1f 12345678 0 0 0 0 19c 1 0 1 0 0
MULS 20 80000000 80000000 0 0 0 1a0 1 4000000000000000 1 0 0
MULS 21 7fffffff 80000000 0 0 0 1a4 1 c000000080000000 1 0 0
MULU 22 80000000 80000000 0 0 0 1a8 1 4000000000000000 1 0 0
MULU 23 ffffffff00000003 5 0 0 0 1ac 1 f 1 0 0
MULS 24 fffffffd 7 0 0 0 1b0 1 ffffffffffffffeb 1 0 0
CLRT 00 0 0 0 0 0 1b4 0 0 0 0 0
NOP 00 0 0 0 0 0 1b8 0 0 0 0 0
